/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check the log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_mcu_cmd -Mdir obj_dir -f compile.f
	./obj_dir/Vtb_mcu_cmd 2>&1 | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || { echo "simulation ended without a verdict"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

/* compile.f */
+incdir+include
source/mcu_cmd_pkg.sv
source/spi_cmd_if.sv
source/cmd_decode.sv
source/config_regs.sv
source/addr_pointer.sv
source/mem_access.sv
source/mcu_cmd_top.sv
test/mem_bus_model.sv
test/tb_mcu_cmd.sv

/* include/mcu_cmd_consts.svh */
`ifndef MCU_CMD_CONSTS_SVH
`define MCU_CMD_CONSTS_SVH

////////////////////////////////////////////////////////////
// widths
////////////////////////////////////////////////////////////

// byte width on both the SPI and the memory side
`define MCU_DATA_W 8
`define ADDR_W 24
`define MAPPER_W 3
// saturated byte position within a command
`define BYTE_IDX_W 4

// mapper comes up as 1, all other config regs as 0
`define MAPPER_RESET 3'd1

////////////////////////////////////////////////////////////
// opcodes
////////////////////////////////////////////////////////////

// command groups, upper nibble of the command byte
`define OP_GRP_ADDR 4'h0
`define OP_GRP_ROM_MASK 4'h1
`define OP_GRP_SRAM_MASK 4'h2
`define OP_GRP_MAPPER 4'h3
`define OP_GRP_READ 4'h8
`define OP_GRP_WRITE 4'h9

// full byte opcodes
`define OP_FEATURES 8'hED
`define OP_REGION 8'hEE
`define OP_ECHO_ID 8'hF0
`define OP_ECHO_PARAM 8'hFF

// identity reply
`define ECHO_ID_BYTE 8'hA5

`endif

/* source/addr_pointer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mcu_cmd_consts.svh"

module addr_pointer
  import mcu_cmd_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,
  spi_cmd_if.sink ev,
  input  logic    next_addr,
  output addr_t   addr_out
);

  logic load;
  logic grp_mem;
  logic inc;

  assign load = ev.param_strobe && (ev.cmd.f.group == `OP_GRP_ADDR);

  // reads and writes only
  assign grp_mem = (ev.cmd.f.group == `OP_GRP_READ) ||
                   (ev.cmd.f.group == `OP_GRP_WRITE);

  // skip_first holds back the count by one byte
  assign inc = next_addr && grp_mem && ev.cmd.f.auto_inc &&
               (ev.byte_idx >= (byte_idx_t'(1) + byte_idx_t'(ev.cmd.f.skip_first)));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      addr_out <= '0;
    end else if (load) begin
      case (ev.byte_idx)
        // top byte starts a new address
        byte_idx_t'(2): addr_out <= {ev.data, 16'h0000};
        byte_idx_t'(3): addr_out[15:8] <= ev.data;
        byte_idx_t'(4): addr_out[7:0] <= ev.data;
        default: ;
      endcase
    end else if (inc) begin
      addr_out <= addr_out + addr_t'(1);
    end
  end

endmodule

`default_nettype wire

/* source/cmd_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mcu_cmd_consts.svh"

module cmd_decode
  import mcu_cmd_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   cmd_ready,
  input  logic                   param_ready,
  input  logic [`MCU_DATA_W-1:0] cmd_data,
  input  logic [`MCU_DATA_W-1:0] param_data,
  input  logic [31:0]            spi_byte_cnt,
  spi_cmd_if.src                 ev
);

  byte_idx_t cnt_sat;

  // byte counts past the index range pin at the top value
  assign cnt_sat = (|spi_byte_cnt[31:`BYTE_IDX_W]) ? '1 :
                   spi_byte_cnt[`BYTE_IDX_W-1:0];

  ////////////////////////////////////////////////////////////
  // strobes, command and byte position
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ev.cmd_strobe   <= 1'b0;
      ev.param_strobe <= 1'b0;
      ev.cmd          <= '0;
      ev.byte_idx     <= '0;
    end else begin
      ev.cmd_strobe   <= cmd_ready;
      ev.param_strobe <= param_ready;
      if (cmd_ready) begin
        ev.cmd.opcode <= cmd_data;
      end
      // position is kept until the next byte
      if (cmd_ready || param_ready) begin
        ev.byte_idx <= cnt_sat;
      end
    end
  end

  // parameter byte
  always_ff @(posedge clk) begin
    if (param_ready) begin
      ev.data <= param_data;
    end
  end

endmodule

`default_nettype wire

/* source/config_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mcu_cmd_consts.svh"

module config_regs
  import mcu_cmd_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n,
  spi_cmd_if.sink                ev,
  output logic [`MAPPER_W-1:0]   mcu_mapper,
  output mask_t                  rom_mask_out,
  output mask_t                  saveram_mask_out,
  output logic [`MCU_DATA_W-1:0] featurebits_out,
  output logic                   region_out
);

  // mask bytes arrive msb first at positions 2, 3 and 4
  function automatic mask_t put_mask_byte(input mask_t m, input byte_idx_t idx,
                                          input logic [`MCU_DATA_W-1:0] d);
    mask_t r;
    r = m;
    case (idx)
      byte_idx_t'(2): r[23:16] = d;
      byte_idx_t'(3): r[15:8] = d;
      byte_idx_t'(4): r[7:0] = d;
      default: r = m;
    endcase
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // mapper and masks
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mcu_mapper       <= `MAPPER_RESET;
      rom_mask_out     <= '0;
      saveram_mask_out <= '0;
    end else if (ev.cmd_strobe) begin
      if (ev.cmd.f.group == `OP_GRP_MAPPER) begin
        mcu_mapper <= {ev.cmd.f.skip_first, ev.cmd.f.sub};
      end
    end else if (ev.param_strobe) begin
      case (ev.cmd.f.group)
        `OP_GRP_ROM_MASK:
          rom_mask_out <= put_mask_byte(rom_mask_out, ev.byte_idx, ev.data);
        `OP_GRP_SRAM_MASK:
          saveram_mask_out <= put_mask_byte(saveram_mask_out, ev.byte_idx, ev.data);
        default: ;
      endcase
    end
  end

  // feature bits and region, whole byte opcodes
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      featurebits_out <= '0;
      region_out      <= 1'b0;
    end else if (ev.param_strobe) begin
      if (ev.cmd.opcode == `OP_FEATURES) begin
        featurebits_out <= ev.data;
      end
      if (ev.cmd.opcode == `OP_REGION) begin
        region_out <= ev.data[0];
      end
    end
  end

endmodule

`default_nettype wire

/* source/mcu_cmd_pkg.sv */
`default_nettype none

`include "mcu_cmd_consts.svh"

package mcu_cmd_pkg;

  // field view of a command byte, msb first
  typedef struct packed {
    logic [3:0] group;
    logic       skip_first;
    logic       auto_inc;
    logic [1:0] sub;
  } cmd_fields_s;

  // the same byte seen either as a plain opcode or as fields
  typedef union packed {
    logic [`MCU_DATA_W-1:0] opcode;
    cmd_fields_s            f;
  } cmd_byte_u;

  // memory address
  typedef logic [`ADDR_W-1:0] addr_t;

  // rom / save-ram address masks
  typedef logic [`ADDR_W-1:0] mask_t;

  // byte position in the current command, saturates at all ones
  typedef logic [`BYTE_IDX_W-1:0] byte_idx_t;

endpackage

`default_nettype wire

/* source/mcu_cmd_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mcu_cmd_consts.svh"

module mcu_cmd_top
  import mcu_cmd_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n,
  // spi side
  input  logic                   cmd_ready,
  input  logic                   param_ready,
  input  logic [`MCU_DATA_W-1:0] cmd_data,
  input  logic [`MCU_DATA_W-1:0] param_data,
  input  logic [31:0]            spi_byte_cnt,
  output logic [`MCU_DATA_W-1:0] spi_data_out,
  // memory side
  output logic                   mcu_rrq,
  output logic                   mcu_wrq,
  output logic [`MCU_DATA_W-1:0] mcu_data_out,
  output addr_t                  addr_out,
  input  logic                   mcu_rq_rdy,
  input  logic [`MCU_DATA_W-1:0] mcu_data_in,
  // configuration
  output logic [`MAPPER_W-1:0]   mcu_mapper,
  output mask_t                  rom_mask_out,
  output mask_t                  saveram_mask_out,
  output logic [`MCU_DATA_W-1:0] featurebits_out,
  output logic                   region_out
);

  spi_cmd_if ev ();

  logic next_addr;

  // stage 1
  cmd_decode u_cmd_decode (
    .clk          (clk),
    .arst_n       (arst_n),
    .cmd_ready    (cmd_ready),
    .param_ready  (param_ready),
    .cmd_data     (cmd_data),
    .param_data   (param_data),
    .spi_byte_cnt (spi_byte_cnt),
    .ev           (ev.src)
  );

  // stage 2
  config_regs u_config_regs (
    .clk              (clk),
    .arst_n           (arst_n),
    .ev               (ev.sink),
    .mcu_mapper       (mcu_mapper),
    .rom_mask_out     (rom_mask_out),
    .saveram_mask_out (saveram_mask_out),
    .featurebits_out  (featurebits_out),
    .region_out       (region_out)
  );

  addr_pointer u_addr_pointer (
    .clk       (clk),
    .arst_n    (arst_n),
    .ev        (ev.sink),
    .next_addr (next_addr),
    .addr_out  (addr_out)
  );

  // stage 3
  mem_access u_mem_access (
    .clk          (clk),
    .arst_n       (arst_n),
    .ev           (ev.sink),
    .mcu_rq_rdy   (mcu_rq_rdy),
    .mcu_data_in  (mcu_data_in),
    .mcu_rrq      (mcu_rrq),
    .mcu_wrq      (mcu_wrq),
    .mcu_data_out (mcu_data_out),
    .spi_data_out (spi_data_out),
    .next_addr    (next_addr)
  );

endmodule

`default_nettype wire

/* source/mem_access.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mcu_cmd_consts.svh"

module mem_access (
  input  logic                   clk,
  input  logic                   arst_n,
  spi_cmd_if.sink                ev,
  input  logic                   mcu_rq_rdy,
  input  logic [`MCU_DATA_W-1:0] mcu_data_in,
  output logic                   mcu_rrq,
  output logic                   mcu_wrq,
  output logic [`MCU_DATA_W-1:0] mcu_data_out,
  output logic [`MCU_DATA_W-1:0] spi_data_out,
  output logic                   next_addr
);

  logic       any_strobe;
  logic       is_read;
  logic       is_write;
  logic [1:0] rdy_sync;
  logic       rdy_sync_d;

  assign any_strobe = ev.cmd_strobe | ev.param_strobe;
  assign is_read    = (ev.cmd.f.group == `OP_GRP_READ);
  assign is_write   = (ev.cmd.f.group == `OP_GRP_WRITE);

  ////////////////////////////////////////////////////////////
  // request pulses
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mcu_rrq <= 1'b0;
      mcu_wrq <= 1'b0;
    end else begin
      // a read fires on the command byte and on every parameter byte
      mcu_rrq <= any_strobe && is_read;
      mcu_wrq <= ev.param_strobe && is_write;
    end
  end

  // write data goes out with the request
  always_ff @(posedge clk) begin
    if (ev.param_strobe && is_write) begin
      mcu_data_out <= ev.data;
    end
  end

  ////////////////////////////////////////////////////////////
  // completion
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rdy_sync   <= 2'b00;
      rdy_sync_d <= 1'b0;
    end else begin
      rdy_sync   <= {rdy_sync[0], mcu_rq_rdy};
      rdy_sync_d <= rdy_sync[1];
    end
  end

  // rising edge of the synchronised ready
  assign next_addr = rdy_sync[1] & ~rdy_sync_d;

  ////////////////////////////////////////////////////////////
  // reply byte
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      spi_data_out <= '0;
    end else if (next_addr && is_read) begin
      spi_data_out <= mcu_data_in;
    end else if (any_strobe) begin
      if (ev.cmd.opcode == `OP_ECHO_ID) begin
        spi_data_out <= `ECHO_ID_BYTE;
      end else if (ev.param_strobe && (ev.cmd.opcode == `OP_ECHO_PARAM)) begin
        spi_data_out <= ev.data;
      end
    end
  end

endmodule

`default_nettype wire

/* source/spi_cmd_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mcu_cmd_consts.svh"

interface spi_cmd_if
  import mcu_cmd_pkg::*;
();

  // single cycle, never both high
  logic                   cmd_strobe;
  logic                   param_strobe;
  // held between command strobes
  cmd_byte_u              cmd;
  // valid with a strobe
  byte_idx_t              byte_idx;
  logic [`MCU_DATA_W-1:0] data;

  modport src (output cmd_strobe, param_strobe, cmd, byte_idx, data);
  modport sink (input cmd_strobe, param_strobe, cmd, byte_idx, data);

endinterface

`default_nettype wire

/* test/mem_bus_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mcu_cmd_consts.svh"

module mem_bus_model #(
  parameter logic [31:0] SEED       = 32'h1,
  parameter int unsigned MAX_DELAY  = 3,
  parameter int unsigned RDY_CYCLES = 3,
  parameter int unsigned DRIVE_DLY  = 2
) (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   mcu_rrq,
  input  logic                   mcu_wrq,
  input  logic [`MCU_DATA_W-1:0] mcu_data_out,
  input  logic [`ADDR_W-1:0]     addr_out,
  output logic                   mcu_rq_rdy,
  output logic [`MCU_DATA_W-1:0] mcu_data_in,
  output int                     wr_count,
  output logic [`ADDR_W-1:0]     last_wr_addr,
  output logic [`MCU_DATA_W-1:0] last_wr_data
);

  int unsigned            delay_cyc;
  logic [`MCU_DATA_W-1:0] rd_byte;

  // one request at a time with ready held high for a fixed number of cycles
  initial begin
    void'($urandom(SEED));
    mcu_rq_rdy   = 1'b0;
    mcu_data_in  = '0;
    wr_count     <= 0;
    last_wr_addr <= '0;
    last_wr_data <= '0;
    forever begin
      @(posedge clk);
      if (arst_n && (mcu_rrq || mcu_wrq)) begin
        // read data follows the request address
        rd_byte = addr_out[7:0] ^ 8'h5A;
        if (mcu_wrq) begin
          last_wr_addr <= addr_out;
          last_wr_data <= mcu_data_out;
          wr_count     <= wr_count + 1;
        end
        delay_cyc = $urandom_range(MAX_DELAY, 0);
        repeat (delay_cyc) @(posedge clk);
        #(DRIVE_DLY);
        mcu_data_in = rd_byte;
        mcu_rq_rdy  = 1'b1;
        repeat (RDY_CYCLES) @(posedge clk);
        #(DRIVE_DLY);
        mcu_rq_rdy = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* test/tb_mcu_cmd.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mcu_cmd_consts.svh"

module tb_mcu_cmd
  import mcu_cmd_pkg::*;
();

  localparam int CLK_PERIOD    = 100;
  localparam int DRIVE_DLY     = 2;
  localparam int RESET_CYCLES  = 4;
  localparam int N_ROWS        = 31;
  // request timing, random delay, ready window and settling fit well inside this
  localparam int ROW_BOUND_CYC = 30;

  localparam logic       CMD = 1'b1;
  localparam logic       PRM = 1'b0;
  localparam logic [1:0] NO  = 2'b00;
  localparam logic [1:0] RD  = 2'b01;
  localparam logic [1:0] WR  = 2'b10;

  logic                   clk = 1'b0;
  logic                   arst_n;
  logic                   cmd_ready;
  logic                   param_ready;
  logic [`MCU_DATA_W-1:0] cmd_data;
  logic [`MCU_DATA_W-1:0] param_data;
  logic [31:0]            spi_byte_cnt;
  logic [`MCU_DATA_W-1:0] spi_data_out;
  logic                   mcu_rrq;
  logic                   mcu_wrq;
  logic [`MCU_DATA_W-1:0] mcu_data_out;
  addr_t                  addr_out;
  logic                   mcu_rq_rdy;
  logic [`MCU_DATA_W-1:0] mcu_data_in;
  logic [`MAPPER_W-1:0]   mcu_mapper;
  mask_t                  rom_mask_out;
  mask_t                  saveram_mask_out;
  logic [`MCU_DATA_W-1:0] featurebits_out;
  logic                   region_out;
  int                     wr_count;
  addr_t                  last_wr_addr;
  logic [`MCU_DATA_W-1:0] last_wr_data;

  // one entry per spi byte
  logic                   row_kind  [N_ROWS];
  logic [31:0]            row_cnt   [N_ROWS];
  logic [`MCU_DATA_W-1:0] row_data  [N_ROWS];
  logic [1:0]             row_req   [N_ROWS];
  logic [`MCU_DATA_W-1:0] row_reply [N_ROWS];
  addr_t                  row_addr  [N_ROWS];
  int                     n_rows = 0;

  int n_checks   = 0;
  int val_errs   = 0;
  int other_errs = 0;
  int rrq_cycles = 0;
  int wrq_cycles = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  mcu_cmd_top uut (.*);

  mem_bus_model #(
    .SEED      (32'hc73c485b),
    .DRIVE_DLY (DRIVE_DLY)
  ) u_mem (
    .clk          (clk),
    .arst_n       (arst_n),
    .mcu_rrq      (mcu_rrq),
    .mcu_wrq      (mcu_wrq),
    .mcu_data_out (mcu_data_out),
    .addr_out     (addr_out),
    .mcu_rq_rdy   (mcu_rq_rdy),
    .mcu_data_in  (mcu_data_in),
    .wr_count     (wr_count),
    .last_wr_addr (last_wr_addr),
    .last_wr_data (last_wr_data)
  );

  // request cycles over the whole run, reset included
  always @(posedge clk) begin
    if (mcu_rrq === 1'b1) rrq_cycles <= rrq_cycles + 1;
    if (mcu_wrq === 1'b1) wrq_cycles <= wrq_cycles + 1;
  end

  task automatic next_cycle();
    @(posedge clk);
    #(DRIVE_DLY);
  endtask

  task automatic check_val(input string name, input logic [31:0] seen,
                           input logic [31:0] exp);
    n_checks++;
    assert (seen === exp) else begin
      val_errs++;
      $display("ERR t=%0t %s seen 0x%0h expected 0x%0h", $time, name, seen, exp);
    end
  endtask

  task automatic add_row(input logic kind, input int cnt, input logic [7:0] data,
                         input logic [1:0] req, input logic [7:0] reply, input addr_t addr);
    if (n_rows < N_ROWS) begin
      row_kind[n_rows]  = kind;
      row_cnt[n_rows]   = cnt;
      row_data[n_rows]  = data;
      row_req[n_rows]   = req;
      row_reply[n_rows] = reply;
      row_addr[n_rows]  = addr;
    end
    n_rows++;
  endtask

  ////////////////////////////////////////////////////////////
  // kind, byte count, data, request, reply, address after the row
  ////////////////////////////////////////////////////////////

  task automatic fill_table();
    add_row(CMD, 1, 8'h3A, NO, 8'h00, 24'h000000);
    // rom mask, then save-ram mask, msb first
    add_row(CMD, 1, 8'h10, NO, 8'h00, 24'h000000);
    add_row(PRM, 2, 8'h3F, NO, 8'h00, 24'h000000);
    add_row(PRM, 3, 8'hFF, NO, 8'h00, 24'h000000);
    add_row(PRM, 4, 8'hFF, NO, 8'h00, 24'h000000);
    add_row(CMD, 1, 8'h20, NO, 8'h00, 24'h000000);
    add_row(PRM, 2, 8'h00, NO, 8'h00, 24'h000000);
    add_row(PRM, 3, 8'h1F, NO, 8'h00, 24'h000000);
    add_row(PRM, 4, 8'hFF, NO, 8'h00, 24'h000000);
    add_row(CMD, 1, 8'hED, NO, 8'h00, 24'h000000);
    add_row(PRM, 2, 8'h4C, NO, 8'h00, 24'h000000);
    add_row(CMD, 1, 8'hEE, NO, 8'h00, 24'h000000);
    add_row(PRM, 2, 8'h01, NO, 8'h00, 24'h000000);
    // address load
    add_row(CMD, 1, 8'h00, NO, 8'h00, 24'h000000);
    add_row(PRM, 2, 8'h12, NO, 8'h00, 24'h120000);
    add_row(PRM, 3, 8'h34, NO, 8'h00, 24'h123400);
    add_row(PRM, 4, 8'h56, NO, 8'h00, 24'h123456);
    // read with auto increment
    add_row(CMD, 1, 8'h84, RD, 8'h0C, 24'h123457);
    add_row(PRM, 2, 8'h00, RD, 8'h0D, 24'h123458);
    add_row(PRM, 3, 8'h00, RD, 8'h02, 24'h123459);
    // write with auto increment
    add_row(CMD, 1, 8'h94, NO, 8'h02, 24'h123459);
    add_row(PRM, 2, 8'hA1, WR, 8'h02, 24'h12345A);
    add_row(PRM, 3, 8'hB2, WR, 8'h02, 24'h12345B);
    // skip_first holds the first increment back
    add_row(CMD, 1, 8'h8C, RD, 8'h01, 24'h12345B);
    // a byte count of 16 saturates instead of wrapping to 0
    add_row(PRM, 16, 8'h00, RD, 8'h01, 24'h12345C);
    add_row(CMD, 1, 8'hF0, NO, 8'hA5, 24'h12345C);
    add_row(CMD, 1, 8'hFF, NO, 8'hA5, 24'h12345C);
    add_row(PRM, 2, 8'h3C, NO, 8'h3C, 24'h12345C);
    add_row(PRM, 40, 8'hC3, NO, 8'hC3, 24'h12345C);
    // read, no increment
    add_row(CMD, 1, 8'h80, RD, 8'h06, 24'h12345C);
    add_row(PRM, 2, 8'h00, RD, 8'h06, 24'h12345C);
  endtask

  task automatic apply_row(input int r, input addr_t wr_addr_exp);
    cmd_ready    = (row_kind[r] == CMD);
    param_ready  = (row_kind[r] == PRM);
    spi_byte_cnt = row_cnt[r];
    if (row_kind[r] == CMD) begin
      cmd_data = row_data[r];
    end else begin
      param_data = row_data[r];
    end
    next_cycle();
    cmd_ready   = 1'b0;
    param_ready = 1'b0;
    check_val("mcu_rrq", 32'(mcu_rrq), 32'd0);
    check_val("mcu_wrq", 32'(mcu_wrq), 32'd0);
    // requests come two cycles after the strobe and last one cycle
    next_cycle();
    check_val("mcu_rrq", 32'(mcu_rrq), 32'(row_req[r] == RD));
    check_val("mcu_wrq", 32'(mcu_wrq), 32'(row_req[r] == WR));
    if (row_req[r] == WR) begin
      check_val("mcu_data_out", 32'(mcu_data_out), 32'(row_data[r]));
    end
    next_cycle();
    check_val("mcu_rrq", 32'(mcu_rrq), 32'd0);
    check_val("mcu_wrq", 32'(mcu_wrq), 32'd0);
    if (row_req[r] != NO) begin
      wait (mcu_rq_rdy);
      wait (!mcu_rq_rdy);
    end
    // let the ready synchroniser drain
    repeat (3) next_cycle();
    check_val("spi_data_out", 32'(spi_data_out), 32'(row_reply[r]));
    check_val("addr_out", 32'(addr_out), 32'(row_addr[r]));
    if (row_req[r] == WR) begin
      check_val("last_wr_addr", 32'(last_wr_addr), 32'(wr_addr_exp));
      check_val("last_wr_data", 32'(last_wr_data), 32'(row_data[r]));
    end
  endtask

  task automatic check_state(input logic [2:0] mapper, input mask_t rom, input mask_t sram,
                             input logic [7:0] feat, input logic region);
    check_val("mcu_mapper", 32'(mcu_mapper), 32'(mapper));
    check_val("rom_mask_out", 32'(rom_mask_out), 32'(rom));
    check_val("saveram_mask_out", 32'(saveram_mask_out), 32'(sram));
    check_val("featurebits_out", 32'(featurebits_out), 32'(feat));
    check_val("region_out", 32'(region_out), 32'(region));
  endtask

  initial begin
    addr_t prev_addr;
    int    exp_rrq;
    int    exp_wrq;
    arst_n       = 1'b0;
    cmd_ready    = 1'b0;
    param_ready  = 1'b0;
    cmd_data     = '0;
    param_data   = '0;
    spi_byte_cnt = '0;
    prev_addr    = '0;
    exp_rrq      = 0;
    exp_wrq      = 0;
    fill_table();
    if (n_rows != N_ROWS) begin
      other_errs++;
      $display("stimulus table holds %0d rows instead of %0d", n_rows, N_ROWS);
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DLY);
    arst_n = 1'b1;
    repeat (3) next_cycle();
    check_state(3'd1, 24'h000000, 24'h000000, 8'h00, 1'b0);
    check_val("addr_out", 32'(addr_out), 32'd0);
    check_val("mcu_rrq cycles", 32'(rrq_cycles), 32'd0);
    check_val("mcu_wrq cycles", 32'(wrq_cycles), 32'd0);
    for (int r = 0; r < N_ROWS && r < n_rows; r++) begin
      apply_row(r, prev_addr);
      prev_addr = row_addr[r];
      exp_rrq   = exp_rrq + ((row_req[r] == RD) ? 1 : 0);
      exp_wrq   = exp_wrq + ((row_req[r] == WR) ? 1 : 0);
    end
    check_state(3'd6, 24'h3FFFFF, 24'h001FFF, 8'h4C, 1'b1);
    check_val("mcu_rrq cycles", 32'(rrq_cycles), 32'(exp_rrq));
    check_val("mcu_wrq cycles", 32'(wrq_cycles), 32'(exp_wrq));
    check_val("wr_count", 32'(wr_count), 32'(exp_wrq));
    $display("checks %0d, value errors %0d, other errors %0d", n_checks, val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #((RESET_CYCLES + 4 + N_ROWS * ROW_BOUND_CYC) * CLK_PERIOD);
    $display("watchdog expired before the stimulus table was done");
    $display("checks %0d, value errors %0d, other errors %0d", n_checks, val_errs, other_errs);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
